// File: design/isa_types_pkg.sv
package isa_types_pkg;

    // ----------------------------------------
    // Core widths
    // ----------------------------------------

    // Address and data width
    localparam int XLEN = 32;

    // Register file sizes
    localparam int ARCH_REG_NUM = 32;
    localparam int PHY_REG_NUM  = 64;

    // ----------------------------------------
    // Register and address types
    // ----------------------------------------

    // Architectural register number
    typedef logic [$clog2(ARCH_REG_NUM)-1:0] arch_reg_t;

    // Physical register tag
    typedef logic [$clog2(PHY_REG_NUM)-1:0] tag_t;

    // Fetch or branch target address
    typedef logic [XLEN-1:0] addr_t;

endpackage

// File: design/rob_pkg.sv
package rob_pkg;
    import isa_types_pkg::*;

    // Index width, caps the buffer at 32 entries
    localparam int ROB_IDX_W = 5;

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // ----------------------------------------
    // Dispatch and broadcast
    // ----------------------------------------

    // One dispatched instruction
    typedef struct packed {
        arch_reg_t rd;
        tag_t      tag;
        // Previous mapping of rd, freed at retire
        tag_t      tag_old;
        logic      br_predict;
    } dp_slot_t;

    // One completion channel
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     br_result;
        addr_t    br_target;
    } cdb_t;

    // ----------------------------------------
    // Storage and retire
    // ----------------------------------------

    // Stored entry
    typedef struct packed {
        logic      valid;
        logic      complete;
        arch_reg_t rd;
        tag_t      tag;
        tag_t      tag_old;
        logic      br_predict;
        logic      br_result;
        addr_t     br_target;
    } rob_entry_t;

    // Map table and free list update, one per retire slot
    typedef struct packed {
        logic      wr_en;
        arch_reg_t arch_reg;
        tag_t      tag;
        tag_t      tag_old;
    } retire_t;

endpackage

// File: design/rob_pointers.sv
`timescale 1ns/1ns

module rob_pointers import rob_pkg::*; #(
    parameter int  ENTRY_NUM = 8,
    parameter int  DP_NUM    = 2,
    parameter int  RT_NUM    = 2,
    localparam int DP_CNT_W  = $clog2(DP_NUM + 1),
    localparam int RT_CNT_W  = $clog2(RT_NUM + 1)
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       exception_i,
    input  logic                       flush_i,
    input  logic     [DP_CNT_W-1:0]    dp_num_i,
    input  logic     [RT_CNT_W-1:0]    rt_num_i,
    output rob_idx_t                   head_o,
    output rob_idx_t                   tail_o,
    output logic     [DP_CNT_W-1:0]    avail_o,
    output rob_idx_t [DP_NUM-1:0]      rob_idx_o
);

    // Wrap flags, toggled each time a pointer passes the last entry
    logic head_wrap;
    logic tail_wrap;

    // Unwrapped pointer sums
    int head_sum;
    int tail_sum;

    // Free entries and capped credit
    int free_cnt;
    int credit;

    // ----------------------------------------
    // Next pointers and credit
    // ----------------------------------------
    always_comb begin
        head_sum = int'(head_o) + int'(rt_num_i);
        tail_sum = int'(tail_o) + int'(dp_num_i);

        // Equal flags: tail is ahead of head in the same lap
        if (head_wrap == tail_wrap) begin
            free_cnt = ENTRY_NUM - (int'(tail_o) - int'(head_o));
        end else begin
            free_cnt = int'(head_o) - int'(tail_o);
        end

        // Entries retiring now count as free for this dispatch
        credit = free_cnt + int'(rt_num_i);
        if (credit > DP_NUM) begin
            credit = DP_NUM;
        end
        avail_o = DP_CNT_W'(credit);
    end

    // Consecutive indices for the dispatch slots
    always_comb begin
        int slot_idx;
        for (int k = 0; k < DP_NUM; k++) begin
            slot_idx = int'(tail_o) + k;
            if (slot_idx >= ENTRY_NUM) begin
                slot_idx = slot_idx - ENTRY_NUM;
            end
            rob_idx_o[k] = rob_idx_t'(slot_idx);
        end
    end

    // ----------------------------------------
    // Pointer registers
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        // Either flush empties the buffer
        if (rst_i || exception_i || flush_i) begin
            head_o    <= '0;
            tail_o    <= '0;
            head_wrap <= 1'b0;
            tail_wrap <= 1'b0;
        end else begin
            if (head_sum >= ENTRY_NUM) begin
                head_o    <= rob_idx_t'(head_sum - ENTRY_NUM);
                head_wrap <= ~head_wrap;
            end else begin
                head_o <= rob_idx_t'(head_sum);
            end

            if (tail_sum >= ENTRY_NUM) begin
                tail_o    <= rob_idx_t'(tail_sum - ENTRY_NUM);
                tail_wrap <= ~tail_wrap;
            end else begin
                tail_o <= rob_idx_t'(tail_sum);
            end
        end
    end

endmodule

// File: design/rob_entry_array.sv
`timescale 1ns/1ns

module rob_entry_array import isa_types_pkg::*; import rob_pkg::*; #(
    parameter int  ENTRY_NUM = 8,
    parameter int  DP_NUM    = 2,
    parameter int  CDB_NUM   = 2,
    localparam int DP_CNT_W  = $clog2(DP_NUM + 1)
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          exception_i,
    input  logic                          flush_i,
    input  rob_idx_t                      tail_i,
    input  logic       [DP_CNT_W-1:0]     dp_num_i,
    input  dp_slot_t   [DP_NUM-1:0]       dp_slot_i,
    input  cdb_t       [CDB_NUM-1:0]      cdb_i,
    input  logic       [ENTRY_NUM-1:0]    rt_sel_i,
    output rob_entry_t [ENTRY_NUM-1:0]    entries_o
);

    // Dispatch select and new entry contents
    logic       [ENTRY_NUM-1:0] dp_sel;
    rob_entry_t [ENTRY_NUM-1:0] dp_entry;

    // Completion hit and winning channel data
    logic       [ENTRY_NUM-1:0] cp_sel;
    logic       [ENTRY_NUM-1:0] cp_result;
    addr_t      [ENTRY_NUM-1:0] cp_target;

    // ----------------------------------------
    // Dispatch mask
    // ----------------------------------------
    always_comb begin
        int offset;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            // Distance from tail, wrapped
            offset = e - int'(tail_i);
            if (offset < 0) begin
                offset = offset + ENTRY_NUM;
            end
            dp_sel[e] = (offset < int'(dp_num_i));

            // New entry: valid, not yet complete
            dp_entry[e]       = '0;
            dp_entry[e].valid = 1'b1;
            if (offset < DP_NUM) begin
                dp_entry[e].rd         = dp_slot_i[offset].rd;
                dp_entry[e].tag        = dp_slot_i[offset].tag;
                dp_entry[e].tag_old    = dp_slot_i[offset].tag_old;
                dp_entry[e].br_predict = dp_slot_i[offset].br_predict;
            end
        end
    end

    // ----------------------------------------
    // Broadcast match
    // ----------------------------------------
    always_comb begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            cp_sel[e]    = 1'b0;
            cp_result[e] = 1'b0;
            cp_target[e] = '0;
            // Later channel overrides, highest number wins
            for (int c = 0; c < CDB_NUM; c++) begin
                if (cdb_i[c].valid && (int'(cdb_i[c].rob_idx) == e)) begin
                    cp_sel[e]    = 1'b1;
                    cp_result[e] = cdb_i[c].br_result;
                    cp_target[e] = cdb_i[c].br_target;
                end
            end
        end
    end

    // ----------------------------------------
    // Entry update
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            if (rst_i || exception_i || flush_i) begin
                entries_o[e] <= '0;
            end else if (dp_sel[e]) begin
                entries_o[e] <= dp_entry[e];
            end else if (rt_sel_i[e]) begin
                entries_o[e] <= '0;
            end else if (cp_sel[e] && entries_o[e].valid) begin
                // Stale broadcast to an empty slot is dropped
                entries_o[e].complete  <= 1'b1;
                entries_o[e].br_result <= cp_result[e];
                entries_o[e].br_target <= cp_target[e];
            end
        end
    end

endmodule

// File: design/rob_retire_select.sv
`timescale 1ns/1ns

module rob_retire_select import isa_types_pkg::*; import rob_pkg::*; #(
    parameter int  ENTRY_NUM = 8,
    parameter int  RT_NUM    = 2,
    localparam int RT_CNT_W  = $clog2(RT_NUM + 1)
) (
    input  rob_idx_t                      head_i,
    input  rob_entry_t [ENTRY_NUM-1:0]    entries_i,
    output logic       [ENTRY_NUM-1:0]    rt_sel_o,
    output logic       [RT_CNT_W-1:0]     rt_num_o,
    output retire_t    [RT_NUM-1:0]       retire_o,
    output logic                          br_mis_valid_o,
    output addr_t                         br_target_o
);

    // ----------------------------------------
    // Retire chain from head
    // ----------------------------------------
    always_comb begin
        int         idx;
        logic       chain;
        logic       ready;
        rob_entry_t ent;

        rt_sel_o       = '0;
        rt_num_o       = '0;
        br_mis_valid_o = 1'b0;
        br_target_o    = '0;
        chain          = 1'b1;

        for (int k = 0; k < RT_NUM; k++) begin
            // Slot k looks at head + k, wrapped
            idx = int'(head_i) + k;
            if (idx >= ENTRY_NUM) begin
                idx = idx - ENTRY_NUM;
            end
            ent   = entries_i[idx];
            ready = chain && ent.valid && ent.complete;

            // Update data for map table and free list
            retire_o[k] = '0;
            if (ready) begin
                retire_o[k].wr_en    = 1'b1;
                retire_o[k].arch_reg = ent.rd;
                retire_o[k].tag      = ent.tag;
                retire_o[k].tag_old  = ent.tag_old;
                rt_sel_o[idx]        = 1'b1;
                rt_num_o             = rt_num_o + RT_CNT_W'(1);

                // Mispredict ends the chain and flushes
                if (ent.br_predict != ent.br_result) begin
                    br_mis_valid_o = 1'b1;
                    br_target_o    = ent.br_target;
                    chain          = 1'b0;
                end
            end else begin
                // Incomplete entry blocks everything behind it
                chain = 1'b0;
            end
        end
    end

endmodule

// File: design/rob_top.sv
`timescale 1ns/1ns

module rob_top import isa_types_pkg::*; import rob_pkg::*; #(
    parameter int  ENTRY_NUM = 8,
    parameter int  DP_NUM    = 2,
    parameter int  CDB_NUM   = 2,
    parameter int  RT_NUM    = 2,
    localparam int DP_CNT_W  = $clog2(DP_NUM + 1),
    localparam int RT_CNT_W  = $clog2(RT_NUM + 1)
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic     [DP_CNT_W-1:0]      dp_num_i,
    input  dp_slot_t [DP_NUM-1:0]        dp_slot_i,
    output logic     [DP_CNT_W-1:0]      avail_o,
    output rob_idx_t [DP_NUM-1:0]        rob_idx_o,
    input  cdb_t     [CDB_NUM-1:0]       cdb_i,
    input  logic                         exception_i,
    output retire_t  [RT_NUM-1:0]        retire_o,
    output logic                         br_mis_valid_o,
    output addr_t                        br_target_o
);

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    rob_idx_t                   head;
    rob_idx_t                   tail;
    logic       [RT_CNT_W-1:0]  rt_num;
    logic       [ENTRY_NUM-1:0] rt_sel;
    rob_entry_t [ENTRY_NUM-1:0] entries;

    // Head, tail and dispatch credit
    rob_pointers #(
        .ENTRY_NUM  (ENTRY_NUM),
        .DP_NUM     (DP_NUM),
        .RT_NUM     (RT_NUM)
    ) rob_pointers_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .exception_i (exception_i),
        .flush_i     (br_mis_valid_o),
        .dp_num_i    (dp_num_i),
        .rt_num_i    (rt_num),
        .head_o      (head),
        .tail_o      (tail),
        .avail_o     (avail_o),
        .rob_idx_o   (rob_idx_o)
    );

    // Entry storage
    rob_entry_array #(
        .ENTRY_NUM  (ENTRY_NUM),
        .DP_NUM     (DP_NUM),
        .CDB_NUM    (CDB_NUM)
    ) rob_entry_array_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .exception_i (exception_i),
        .flush_i     (br_mis_valid_o),
        .tail_i      (tail),
        .dp_num_i    (dp_num_i),
        .dp_slot_i   (dp_slot_i),
        .cdb_i       (cdb_i),
        .rt_sel_i    (rt_sel),
        .entries_o   (entries)
    );

    // In-order retire and mispredict flush
    rob_retire_select #(
        .ENTRY_NUM  (ENTRY_NUM),
        .RT_NUM     (RT_NUM)
    ) rob_retire_select_i (
        .head_i         (head),
        .entries_i      (entries),
        .rt_sel_o       (rt_sel),
        .rt_num_o       (rt_num),
        .retire_o       (retire_o),
        .br_mis_valid_o (br_mis_valid_o),
        .br_target_o    (br_target_o)
    );

endmodule

// File: include/rob_tb_model.svh
`ifndef ROB_TB_MODEL_SVH
`define ROB_TB_MODEL_SVH

// Buffer contents in program order, oldest at the front
rob_entry_t          model_q[$];
// Entry index of the oldest instruction
int                  model_head;

// Expected outputs for the current cycle
retire_t             exp_retire [RT_NUM];
int                  exp_rt_num;
logic                exp_mis;
addr_t               exp_target;
logic [DP_CNT_W-1:0] exp_avail;
rob_idx_t            exp_idx [DP_NUM];

function automatic void model_reset();
    model_q.delete();
    model_head = 0;
endfunction

function automatic void model_predict();
    int         credit;
    rob_entry_t ent;

    exp_rt_num = 0;
    exp_mis    = 1'b0;
    exp_target = '0;
    for (int k = 0; k < RT_NUM; k++) begin
        exp_retire[k] = '0;
        // Slot k retires only if every older slot did
        if (exp_rt_num == k && !exp_mis && k < model_q.size()) begin
            ent = model_q[k];
            if (ent.complete) begin
                exp_retire[k].wr_en    = 1'b1;
                exp_retire[k].arch_reg = ent.rd;
                exp_retire[k].tag      = ent.tag;
                exp_retire[k].tag_old  = ent.tag_old;
                exp_rt_num++;
                // Mispredicted branch is the last one out
                if (ent.br_predict != ent.br_result) begin
                    exp_mis    = 1'b1;
                    exp_target = ent.br_target;
                end
            end
        end
    end

    // Entries retiring now count toward the credit
    credit = ENTRY_NUM - model_q.size() + exp_rt_num;
    if (credit > DP_NUM) begin
        credit = DP_NUM;
    end
    exp_avail = DP_CNT_W'(credit);
    for (int k = 0; k < DP_NUM; k++) begin
        exp_idx[k] = rob_idx_t'((model_head + model_q.size() + k) % ENTRY_NUM);
    end
endfunction

// Edge update from the inputs held during the cycle
function automatic void model_step();
    int         pos;
    rob_entry_t ent;

    model_predict();
    // Either flush drops this cycle's dispatch and completion
    if (exception || exp_mis) begin
        model_reset();
    end else begin
        // Completion of stored entries, later channel wins
        for (int c = 0; c < CDB_NUM; c++) begin
            pos = (int'(cdb[c].rob_idx) - model_head + ENTRY_NUM) % ENTRY_NUM;
            if (cdb[c].valid && pos < model_q.size()) begin
                ent           = model_q[pos];
                ent.complete  = 1'b1;
                ent.br_result = cdb[c].br_result;
                ent.br_target = cdb[c].br_target;
                model_q[pos]  = ent;
            end
        end

        for (int r = 0; r < exp_rt_num; r++) begin
            model_q.delete(0);
        end
        model_head = (model_head + exp_rt_num) % ENTRY_NUM;

        // New entries at the back, valid and not complete
        for (int k = 0; k < int'(dp_num); k++) begin
            ent            = '0;
            ent.valid      = 1'b1;
            ent.rd         = dp_slot[k].rd;
            ent.tag        = dp_slot[k].tag;
            ent.tag_old    = dp_slot[k].tag_old;
            ent.br_predict = dp_slot[k].br_predict;
            model_q.push_back(ent);
        end
    end
endfunction

`endif

// File: tb/rob_tb.sv
`timescale 1ns/1ns

module rob_tb
    import isa_types_pkg::*;
    import rob_pkg::*;
();

    localparam int ENTRY_NUM      = 8;
    localparam int DP_NUM         = 2;
    localparam int CDB_NUM        = 2;
    localparam int RT_NUM         = 2;
    localparam int DP_CNT_W       = $clog2(DP_NUM + 1);
    localparam int RUN_CYCLES     = 2000;
    // Run length plus half again as margin
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 2;

    logic                    clk_i;
    logic                    rst_i;
    logic     [DP_CNT_W-1:0] dp_num;
    dp_slot_t [DP_NUM-1:0]   dp_slot;
    logic     [DP_CNT_W-1:0] avail;
    rob_idx_t [DP_NUM-1:0]   rob_idx;
    cdb_t     [CDB_NUM-1:0]  cdb;
    logic                    exception;
    retire_t  [RT_NUM-1:0]   retire;
    logic                    br_mis_valid;
    addr_t                   br_target;

    // Branch flag per entry index, set at dispatch
    bit                      br_flag [ENTRY_NUM];
    logic [31:0]             rand_state = 32'ha1792f2b;
    int                      cycle_cnt = 0;

    `include "rob_tb_model.svh"

    rob_top #(
        .ENTRY_NUM (ENTRY_NUM),
        .DP_NUM    (DP_NUM),
        .CDB_NUM   (CDB_NUM),
        .RT_NUM    (RT_NUM)
    ) rob_top_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .dp_num_i       (dp_num),
        .dp_slot_i      (dp_slot),
        .avail_o        (avail),
        .rob_idx_o      (rob_idx),
        .cdb_i          (cdb),
        .exception_i    (exception),
        .retire_o       (retire),
        .br_mis_valid_o (br_mis_valid),
        .br_target_o    (br_target)
    );

    // ----------------------------------------
    // Clock and run limit
    // ----------------------------------------
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the run did not end within the cycle limit");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    // LCG, upper half only since low bits repeat quickly
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, rand_state[31:16]};
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_retire(input string name, input retire_t want, input retire_t got);
        // Disabled slot only needs wr_en low
        if (want.wr_en ? (got !== want) : (got.wr_en !== 1'b0)) begin
            abort_run($sformatf("ERR %s: expected %h, actual %h", name, want, got));
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t want, input rob_idx_t got);
        if (got !== want) begin
            abort_run($sformatf("ERR %s: expected %0d, actual %0d", name, want, got));
        end
    endtask

    task automatic check_avail(input string name, input logic [DP_CNT_W-1:0] want,
                               input logic [DP_CNT_W-1:0] got);
        if (got !== want) begin
            abort_run($sformatf("ERR %s: expected %0d, actual %0d", name, want, got));
        end
    endtask

    task automatic check_flush(input string name, input logic want_valid, input addr_t want_tgt,
                               input logic got_valid, input addr_t got_tgt);
        // Target only meaningful with the flush raised
        if (got_valid !== want_valid || (want_valid && got_tgt !== want_tgt)) begin
            abort_run($sformatf("ERR %s: expected %b/%h, actual %b/%h",
                                name, want_valid, want_tgt, got_valid, got_tgt));
        end
    endtask

    task automatic run_checks();
        for (int k = 0; k < RT_NUM; k++) begin
            check_retire($sformatf("retire slot %0d", k), exp_retire[k], retire[k]);
        end
        check_avail("avail", exp_avail, avail);
        for (int k = 0; k < DP_NUM; k++) begin
            check_idx($sformatf("rob_idx slot %0d", k), exp_idx[k], rob_idx[k]);
        end
        check_flush("branch flush", exp_mis, exp_target, br_mis_valid, br_target);
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic drive_inputs();
        int   n;
        int   idx;
        int   pos;
        logic br;

        // Dispatch count within the credit
        n      = int'(next_rand() % 32'(int'(exp_avail) + 1));
        dp_num = DP_CNT_W'(n);
        for (int k = 0; k < DP_NUM; k++) begin
            // About one in eight is a branch
            br                    = (next_rand() % 32'd8) == 32'd0;
            dp_slot[k].rd         = arch_reg_t'(next_rand());
            dp_slot[k].tag        = tag_t'(next_rand());
            dp_slot[k].tag_old    = tag_t'(next_rand());
            dp_slot[k].br_predict = br ? (next_rand() % 32'd2 == 32'd1) : 1'b0;
            if (k < n) begin
                br_flag[int'(exp_idx[k])] = br;
            end
        end

        for (int c = 0; c < CDB_NUM; c++) begin
            cdb[c] = '0;
            idx    = int'(next_rand() % 32'(ENTRY_NUM));
            pos    = (idx - model_head + ENTRY_NUM) % ENTRY_NUM;
            // Completed entries skipped, empty slots go out as stale hits
            if ((next_rand() % 32'd2 == 32'd0) &&
                (pos >= model_q.size() || !model_q[pos].complete)) begin
                cdb[c].valid     = 1'b1;
                cdb[c].rob_idx   = rob_idx_t'(idx);
                // Non-branches resolve the way they were predicted
                cdb[c].br_result = br_flag[idx] ? (next_rand() % 32'd2 == 32'd1) : 1'b0;
                cdb[c].br_target = (next_rand() << 16) | next_rand();
            end
        end

        // Rare external exception
        exception = (next_rand() % 32'd200) == 32'd0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst_i     = 1'b1;
        dp_num    = '0;
        dp_slot   = '0;
        cdb       = '0;
        exception = 1'b0;
        model_reset();
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            // Outputs depend on stored state only
            model_predict();
            run_checks();
            drive_inputs();
            @(posedge clk_i);
            #1;
            model_step();
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
design/isa_types_pkg.sv
design/rob_pkg.sv
design/rob_pointers.sv
design/rob_entry_array.sv
design/rob_retire_select.sv
design/rob_top.sv
tb/rob_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0 -Wno-fatal
TOP      := rob_tb
FLIST    := flist.f
OBJDIR   := obj_dir
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q -F "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
